/* source/priority_encoder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Priority encoder
// Reports the index of the lowest set bit of a vector
// and whether any bit is set at all
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module priority_encoder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         data_in,
    output logic [$clog2(WIDTH)-1:0] index_out,
    output logic                     valid_out
);

    // Scan from the top down so that the lowest set bit is the last one
    // to write the index
    always_comb begin
        index_out = '0;
        valid_out = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (data_in[i]) begin
                index_out = i[$clog2(WIDTH)-1:0];
                valid_out = 1'b1;
            end
        end
    end

endmodule

/* source/request_tracker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request tracker
// Issues tags to incoming requests, records their details
// and issue time, and retires them on response with latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module request_tracker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,

    input  logic                              req_valid,
    input  logic [tracker_pkg::ADDR_W-1:0]    req_addr,
    input  logic [tracker_pkg::SOURCE_W-1:0]  req_source,
    output logic                              req_ready,
    output logic [tracker_pkg::TAG_W-1:0]     req_tag,

    input  logic                              rsp_valid,
    input  logic [tracker_pkg::TAG_W-1:0]     rsp_tag,

    output logic                              done_valid,
    output logic [tracker_pkg::ADDR_W-1:0]    done_addr,
    output logic [tracker_pkg::SOURCE_W-1:0]  done_source,
    output logic [tracker_pkg::STAMP_W-1:0]   done_latency,

    output logic                              accepted,
    output logic [tracker_pkg::COUNT_W-1:0]   in_flight,
    output logic                              empty,
    output logic                              full
);

    logic                              accept;
    tracker_pkg::stamp_t               stamp_r;
    tracker_pkg::stamp_t               issue_stamp;
    tracker_pkg::req_record_t          wr_record;
    tracker_pkg::req_record_t          rd_record;
    logic [tracker_pkg::COUNT_W-1:0]   in_flight_r;

    // Requests wait while disabled or while every tag is in use
    assign req_ready = enable && !full;
    assign accept    = req_valid && req_ready;
    assign accepted  = accept;

    slot_allocator #(
        .SIZE (tracker_pkg::NUM_TAGS)
    ) u_slot_allocator (
        .clk          (clk),
        .reset        (reset),
        .acquire_en   (accept),
        .acquire_addr (req_tag),
        .release_en   (rsp_valid),
        .release_addr (rsp_tag),
        .empty        (empty),
        .full         (full)
    );

    assign wr_record.addr   = req_addr;
    assign wr_record.source = req_source;

    // Address and source of each request in flight
    tag_store #(
        .payload_t (tracker_pkg::req_record_t),
        .DEPTH     (tracker_pkg::NUM_TAGS)
    ) u_record_store (
        .clk        (clk),
        .write_en   (accept),
        .write_tag  (req_tag),
        .write_data (wr_record),
        .read_tag   (rsp_tag),
        .read_data  (rd_record)
    );

    // Cycle stamp taken at the accept edge
    tag_store #(
        .payload_t (tracker_pkg::stamp_t),
        .DEPTH     (tracker_pkg::NUM_TAGS)
    ) u_stamp_store (
        .clk        (clk),
        .write_en   (accept),
        .write_tag  (req_tag),
        .write_data (stamp_r),
        .read_tag   (rsp_tag),
        .read_data  (issue_stamp)
    );

    // Free-running stamp, wraps naturally so the subtraction stays modular
    // In-flight count holds when an accept and a response coincide
    always_ff @(posedge clk) begin
        if (reset) begin
            stamp_r     <= '0;
            in_flight_r <= '0;
        end else begin
            stamp_r <= stamp_r + 1'b1;
            if (accept && !rsp_valid) begin
                in_flight_r <= in_flight_r + 1'b1;
            end else if (rsp_valid && !accept) begin
                in_flight_r <= in_flight_r - 1'b1;
            end
        end
    end

    assign in_flight = in_flight_r;

    // Completion is resolved in the response cycle itself
    assign done_valid   = rsp_valid;
    assign done_addr    = rd_record.addr;
    assign done_source  = rd_record.source;
    assign done_latency = stamp_r - issue_stamp;

endmodule

/* source/slot_allocator.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot allocator
// Keeps a bitmap of free slots and offers the lowest free
// index one cycle ahead, with registered empty and full flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module slot_allocator #(
    parameter int SIZE = tracker_pkg::NUM_TAGS
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    acquire_en,
    output logic [$clog2(SIZE)-1:0] acquire_addr,

    input  logic                    release_en,
    input  logic [$clog2(SIZE)-1:0] release_addr,

    output logic                    empty,
    output logic                    full
);

    // One bit per slot, set while the slot is free
    logic [SIZE-1:0]         free_slots;
    logic [SIZE-1:0]         free_slots_n;
    logic [$clog2(SIZE)-1:0] offer_r;
    logic                    empty_r;
    logic                    full_r;
    logic [$clog2(SIZE)-1:0] free_index;
    logic                    free_valid;

    // Next bitmap after this cycle's release and acquire
    // The acquire always takes the slot currently on offer
    always_comb begin
        free_slots_n = free_slots;
        if (release_en) begin
            free_slots_n[release_addr] = 1'b1;
        end
        if (acquire_en) begin
            free_slots_n[offer_r] = 1'b0;
        end
    end

    // Search the next bitmap so the offer is ready one cycle later
    priority_encoder #(
        .WIDTH (SIZE)
    ) u_free_search (
        .data_in   (free_slots_n),
        .index_out (free_index),
        .valid_out (free_valid)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            free_slots <= {SIZE{1'b1}};
            offer_r    <= '0;
            empty_r    <= 1'b1;
            full_r     <= 1'b0;
        end else begin
            // Any change to the bitmap can move the lowest free slot,
            // including a release that frees a slot below the current offer
            if (acquire_en || release_en) begin
                offer_r <= free_index;
            end
            free_slots <= free_slots_n;
            empty_r    <= &free_slots_n;
            full_r     <= ~free_valid;
        end
    end

    assign acquire_addr = offer_r;
    assign empty        = empty_r;
    assign full         = full_r;

endmodule

/* source/tag_store.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag store
// Register array indexed by tag with one synchronous write
// port and one asynchronous read port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tag_store #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = tracker_pkg::NUM_TAGS
) (
    input  logic                     clk,

    input  logic                     write_en,
    input  logic [$clog2(DEPTH)-1:0] write_tag,
    input  payload_t                 write_data,

    input  logic [$clog2(DEPTH)-1:0] read_tag,
    output payload_t                 read_data
);

    // One entry per tag
    payload_t entries [DEPTH];

    // Entry is filled when its tag is handed out
    always_ff @(posedge clk) begin
        if (write_en) begin
            entries[write_tag] <= write_data;
        end
    end

    // Read is combinational so a response is resolved in its own cycle
    assign read_data = entries[read_tag];

endmodule

/* source/tracker_csr.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tracker register block
// APB slave with the enable control, tracker status,
// accepted-request count and maximum latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tracker_csr (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic [tracker_csr_pkg::CSR_ADDR_W-1:0] paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [tracker_csr_pkg::CSR_DATA_W-1:0] pwdata,
    output logic [tracker_csr_pkg::CSR_DATA_W-1:0] prdata,
    output logic                                  pready,
    output logic                                  pslverr,

    output logic                                  enable,

    input  logic                                  accepted,
    input  logic [tracker_pkg::COUNT_W-1:0]       in_flight,
    input  logic                                  empty,
    input  logic                                  full,
    input  logic                                  done_valid,
    input  logic [tracker_pkg::STAMP_W-1:0]       done_latency
);

    logic                                  access;
    logic                                  wr_access;
    logic                                  mapped;
    logic                                  enable_r;
    logic [tracker_csr_pkg::CSR_DATA_W-1:0] accepted_cnt;
    tracker_pkg::stamp_t                   max_lat;
    logic [tracker_csr_pkg::CSR_DATA_W-1:0] status_word;

    // Zero wait states, so the access phase is always the last one
    assign pready    = 1'b1;
    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    assign mapped = (paddr == tracker_csr_pkg::REG_CTRL)
                 || (paddr == tracker_csr_pkg::REG_STATUS)
                 || (paddr == tracker_csr_pkg::REG_ACCEPTED)
                 || (paddr == tracker_csr_pkg::REG_MAX_LAT);

    assign pslverr = access && !mapped;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_r     <= 1'b0;
            accepted_cnt <= '0;
            max_lat      <= '0;
        end else begin
            if (wr_access && (paddr == tracker_csr_pkg::REG_CTRL)) begin
                enable_r <= pwdata[tracker_csr_pkg::CTRL_ENABLE_BIT];
            end

            // Wraps after 2^32 requests
            if (accepted) begin
                accepted_cnt <= accepted_cnt + 1'b1;
            end

            // A completion in the same cycle as the clear survives it
            if (wr_access && (paddr == tracker_csr_pkg::REG_MAX_LAT)) begin
                max_lat <= done_valid ? done_latency : '0;
            end else if (done_valid && (done_latency > max_lat)) begin
                max_lat <= done_latency;
            end
        end
    end

    assign enable = enable_r;

    always_comb begin
        status_word = '0;
        status_word[tracker_csr_pkg::STATUS_COUNT_W-1:0] = in_flight;
        status_word[tracker_csr_pkg::STATUS_EMPTY_BIT]   = empty;
        status_word[tracker_csr_pkg::STATUS_FULL_BIT]    = full;
    end

    // Read data follows the address; unmapped offsets return zero
    always_comb begin
        prdata = '0;
        case (paddr)
            tracker_csr_pkg::REG_CTRL: begin
                prdata[tracker_csr_pkg::CTRL_ENABLE_BIT] = enable_r;
            end
            tracker_csr_pkg::REG_STATUS: begin
                prdata = status_word;
            end
            tracker_csr_pkg::REG_ACCEPTED: begin
                prdata = accepted_cnt;
            end
            tracker_csr_pkg::REG_MAX_LAT: begin
                prdata = tracker_csr_pkg::CSR_DATA_W'(max_lat);
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

/* source/tracker_csr_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tracker register map
// APB widths, register offsets and bit positions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tracker_csr_pkg;

    localparam int CSR_ADDR_W = 8;
    localparam int CSR_DATA_W = 32;

    // Register offsets
    localparam logic [CSR_ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] REG_STATUS   = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] REG_ACCEPTED = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] REG_MAX_LAT  = 8'h0C;

    // Control and status fields
    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int STATUS_COUNT_W   = 4;
    localparam int STATUS_EMPTY_BIT = 8;
    localparam int STATUS_FULL_BIT  = 9;

endpackage

/* source/tracker_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request tracker definitions
// Widths of tags, addresses, sources and cycle stamps,
// plus the record kept for each request in flight
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tracker_pkg;

    // Number of requests that can be outstanding at once
    localparam int NUM_TAGS = 8;
    localparam int TAG_W    = $clog2(NUM_TAGS);

    // In-flight count has to reach NUM_TAGS itself, hence the extra bit
    localparam int COUNT_W  = TAG_W + 1;

    localparam int ADDR_W   = 32;
    localparam int SOURCE_W = 4;
    localparam int STAMP_W  = 16;

    // Details of one request, stored by tag until its response returns
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [SOURCE_W-1:0] source;
    } req_record_t;

    typedef logic [STAMP_W-1:0] stamp_t;

endpackage

/* source/tracker_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tracker top level
// Joins the request tracker and its APB register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tracker_top (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                                   req_valid,
    input  logic [tracker_pkg::ADDR_W-1:0]         req_addr,
    input  logic [tracker_pkg::SOURCE_W-1:0]       req_source,
    output logic                                   req_ready,
    output logic [tracker_pkg::TAG_W-1:0]          req_tag,

    input  logic                                   rsp_valid,
    input  logic [tracker_pkg::TAG_W-1:0]          rsp_tag,

    output logic                                   done_valid,
    output logic [tracker_pkg::ADDR_W-1:0]         done_addr,
    output logic [tracker_pkg::SOURCE_W-1:0]       done_source,
    output logic [tracker_pkg::STAMP_W-1:0]        done_latency,

    input  logic [tracker_csr_pkg::CSR_ADDR_W-1:0] paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [tracker_csr_pkg::CSR_DATA_W-1:0] pwdata,
    output logic [tracker_csr_pkg::CSR_DATA_W-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr
);

    logic                            enable;
    logic                            accepted;
    logic [tracker_pkg::COUNT_W-1:0] in_flight;
    logic                            empty;
    logic                            full;

    request_tracker u_request_tracker (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_source   (req_source),
        .req_ready    (req_ready),
        .req_tag      (req_tag),
        .rsp_valid    (rsp_valid),
        .rsp_tag      (rsp_tag),
        .done_valid   (done_valid),
        .done_addr    (done_addr),
        .done_source  (done_source),
        .done_latency (done_latency),
        .accepted     (accepted),
        .in_flight    (in_flight),
        .empty        (empty),
        .full         (full)
    );

    // Statistics are fed from the same completion outputs seen outside
    tracker_csr u_tracker_csr (
        .clk          (clk),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .enable       (enable),
        .accepted     (accepted),
        .in_flight    (in_flight),
        .empty        (empty),
        .full         (full),
        .done_valid   (done_valid),
        .done_latency (done_latency)
    );

endmodule

/* tests/tracker_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request tracker testbench
// Random request and response traffic against a model of
// the tag bitmap, stored records, latency and APB registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tracker_tb;

    localparam int NUM_TAGS       = tracker_pkg::NUM_TAGS;
    localparam int TRAFFIC_CYCLES = 2000;
    // Reset, register accesses, fill and drain phases
    localparam int OTHER_CYCLES   = 108;
    localparam int TIMEOUT_CYCLES = 4 * (TRAFFIC_CYCLES + OTHER_CYCLES);

    logic                                   clk;
    logic                                   reset;
    logic                                   req_valid;
    logic [tracker_pkg::ADDR_W-1:0]         req_addr;
    logic [tracker_pkg::SOURCE_W-1:0]       req_source;
    logic                                   req_ready;
    logic [tracker_pkg::TAG_W-1:0]          req_tag;
    logic                                   rsp_valid;
    logic [tracker_pkg::TAG_W-1:0]          rsp_tag;
    logic                                   done_valid;
    logic [tracker_pkg::ADDR_W-1:0]         done_addr;
    logic [tracker_pkg::SOURCE_W-1:0]       done_source;
    logic [tracker_pkg::STAMP_W-1:0]        done_latency;
    logic [tracker_csr_pkg::CSR_ADDR_W-1:0] paddr;
    logic                                   psel;
    logic                                   penable;
    logic                                   pwrite;
    logic [tracker_csr_pkg::CSR_DATA_W-1:0] pwdata;
    logic [tracker_csr_pkg::CSR_DATA_W-1:0] prdata;
    logic                                   pready;
    logic                                   pslverr;

    // Model state, updated at every rising edge by clock_step
    logic [NUM_TAGS-1:0]              m_busy;
    logic [tracker_pkg::ADDR_W-1:0]   m_addr [NUM_TAGS];
    logic [tracker_pkg::SOURCE_W-1:0] m_source [NUM_TAGS];
    int                               m_stamp [NUM_TAGS];
    logic                             m_enable;
    int                               m_accepted;
    logic [tracker_pkg::STAMP_W-1:0]  m_max_lat;

    // Client side request that is held until accepted
    logic                             pend_valid;
    logic [tracker_pkg::ADDR_W-1:0]   pend_addr;
    logic [tracker_pkg::SOURCE_W-1:0] pend_source;

    logic [31:0] rng_state;
    int          cycle_count;
    logic [31:0] apb_rdata;
    logic        apb_err;
    logic        apb_ready;

    tracker_top u_tracker_top (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req_addr (req_addr), .req_source (req_source),
        .req_ready (req_ready), .req_tag (req_tag),
        .rsp_valid (rsp_valid), .rsp_tag (rsp_tag),
        .done_valid (done_valid), .done_addr (done_addr),
        .done_source (done_source), .done_latency (done_latency),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Edge counter, which also gives the latency reference
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (!m_busy[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic int busy_count();
        int n;
        n = 0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            n += m_busy[i];
        end
        return n;
    endfunction

    // Count in bits 3:0, empty in bit 8, full in bit 9
    function automatic logic [31:0] expected_status();
        logic [31:0] word;
        word = busy_count();
        word[8] = (busy_count() == 0);
        word[9] = (busy_count() == NUM_TAGS);
        return word;
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %0h, actual %0h", test, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Checks the current cycle against the model, takes one edge and
    // updates the model with what the DUT saw at that edge
    task automatic clock_step();
        logic                            exp_ready;
        logic                            accept;
        int                              tag;
        int                              cycle_now;
        logic [tracker_pkg::STAMP_W-1:0] exp_lat;
        #1;
        apb_rdata = prdata;
        apb_err   = pslverr;
        apb_ready = pready;
        cycle_now = cycle_count;
        tag       = lowest_free();
        exp_ready = m_enable && (busy_count() < NUM_TAGS);
        check_value("req_ready", exp_ready, req_ready);
        if (exp_ready) begin
            check_value("req_tag", tag, req_tag);
        end
        check_value("done_valid", rsp_valid, done_valid);
        exp_lat = 16'(cycle_now - m_stamp[rsp_tag]);
        if (rsp_valid) begin
            check_value("done_addr", m_addr[rsp_tag], done_addr);
            check_value("done_source", m_source[rsp_tag], done_source);
            check_value("done_latency", exp_lat, done_latency);
        end
        accept = req_valid && exp_ready;
        @(posedge clk);
        if (accept) begin
            m_busy[tag]   = 1'b1;
            m_addr[tag]   = req_addr;
            m_source[tag] = req_source;
            m_stamp[tag]  = cycle_now;
            m_accepted++;
            pend_valid    = 1'b0;
        end
        if (rsp_valid) begin
            m_busy[rsp_tag] = 1'b0;
            if (exp_lat > m_max_lat) begin
                m_max_lat = exp_lat;
            end
        end
        #1;
        req_valid  = pend_valid;
        req_addr   = pend_addr;
        req_source = pend_source;
        rsp_valid  = 1'b0;
    endtask

    // New request with 3/4 chance, response to a random busy tag with 1/2
    task automatic drive_traffic(input bit new_ok, input bit rsp_ok);
        logic [31:0] r;
        int          t;
        r = next_random();
        if (new_ok && !pend_valid && (r[1:0] != 2'b00)) begin
            pend_valid  = 1'b1;
            pend_addr   = next_random();
            pend_source = r[7:4];
        end
        req_valid  = pend_valid;
        req_addr   = pend_addr;
        req_source = pend_source;
        if (rsp_ok && (m_busy != '0) && r[2]) begin
            t = r[10:8];
            while (!m_busy[t]) begin
                t = (t + 1) % NUM_TAGS;
            end
            rsp_valid = 1'b1;
            rsp_tag   = t[tracker_pkg::TAG_W-1:0];
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        clock_step();
        penable = 1'b1;
        clock_step();
        check_value("apb_write_err", 0, apb_err);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (addr == tracker_csr_pkg::REG_CTRL) begin
            m_enable = data[tracker_csr_pkg::CTRL_ENABLE_BIT];
        end
        // No response is driven during register accesses
        if (addr == tracker_csr_pkg::REG_MAX_LAT) begin
            m_max_lat = '0;
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        clock_step();
        penable = 1'b1;
        clock_step();
        check_value("apb_pready", 1, apb_ready);
        data    = apb_rdata;
        err     = apb_err;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        logic [31:0]                   data;
        logic                          err;
        logic [tracker_pkg::TAG_W-1:0] t;
        reset = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_source = '0;
        rsp_valid = 1'b0;
        rsp_tag = '0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        m_busy = '0;
        m_enable = 1'b0;
        m_accepted = 0;
        m_max_lat = '0;
        pend_valid = 1'b0;
        pend_addr = '0;
        pend_source = '0;
        cycle_count = 0;
        rng_state = 32'h27806873;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // A request waits while the tracker is still disabled
        pend_valid  = 1'b1;
        pend_addr   = next_random();
        pend_source = 4'h5;
        req_valid   = 1'b1;
        req_addr    = pend_addr;
        req_source  = pend_source;
        repeat (4) clock_step();
        apb_read(tracker_csr_pkg::REG_STATUS, data, err);
        check_value("reset_status", 32'h0000_0100, data);
        apb_read(8'h10, data, err);
        check_value("unmapped_pslverr", 1, err);

        apb_write(tracker_csr_pkg::REG_CTRL, 32'h1);
        repeat (TRAFFIC_CYCLES) begin
            drive_traffic(1'b1, 1'b1);
            clock_step();
        end

        // Let the last request in so the statistics hold still
        while (pend_valid) begin
            drive_traffic(1'b0, 1'b1);
            clock_step();
        end
        apb_read(tracker_csr_pkg::REG_ACCEPTED, data, err);
        check_value("accepted_count", m_accepted, data);
        apb_read(tracker_csr_pkg::REG_MAX_LAT, data, err);
        check_value("max_latency", m_max_lat, data);
        apb_write(tracker_csr_pkg::REG_MAX_LAT, 32'h0);
        apb_read(tracker_csr_pkg::REG_MAX_LAT, data, err);
        check_value("max_latency_clear", 0, data);

        // Fill every tag with a further request left waiting
        while (!((busy_count() == NUM_TAGS) && pend_valid)) begin
            drive_traffic(1'b1, 1'b0);
            clock_step();
        end
        repeat (3) clock_step();
        apb_read(tracker_csr_pkg::REG_STATUS, data, err);
        check_value("full_status", 32'h0000_0208, data);
        data      = next_random();
        t         = data[tracker_pkg::TAG_W-1:0];
        rsp_valid = 1'b1;
        rsp_tag   = t;
        clock_step();
        #1;
        check_value("freed_ready", 1, req_ready);
        check_value("freed_tag", t, req_tag);
        clock_step();

        // Return everything still in flight
        while ((busy_count() != 0) || pend_valid) begin
            drive_traffic(1'b0, 1'b1);
            clock_step();
        end
        apb_read(tracker_csr_pkg::REG_STATUS, data, err);
        check_value("drained_status", expected_status(), data);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tracker.f */
source/tracker_pkg.sv
source/tracker_csr_pkg.sv
source/priority_encoder.sv
source/slot_allocator.sv
source/tag_store.sv
source/request_tracker.sv
source/tracker_csr.sv
source/tracker_top.sv
tests/tracker_tb.sv
